// File: filelist.f
+incdir+.
rv_types_pkg.sv
rv_agu.sv
rv_branch_cmp.sv
rv_hazard.sv
rv_decode.sv
rv_id_stage.sv
tb_rv_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, then check the log
rm -f sim.log && \
verilator --binary --timing --assert -f filelist.f --top-module tb_rv_id_stage -o sim_tb && \
{ ./obj_dir/sim_tb > sim.log 2>&1; cat sim.log; } && \
grep -q "TESTBENCH PASSED" sim.log && echo "simulation run ok" || \
{ echo "simulation run failed"; exit 1; }

// File: rv_agu.sv
/* Address generator with jump, branch and memory misalignment check */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_agu
  import rv_types_pkg::*;
(
  input  logic [`RV_XLEN-1:0] base,
  input  logic [`RV_XLEN-1:0] offset,
  input  opcode_e             op,
  input  logic [2:0]          funct3,
  output logic [`RV_XLEN-1:0] addr,
  output logic                misaligned
);

  logic [`RV_XLEN-1:0] sum;

  assign sum = base + offset;

  // JALR target drops bit 0
  assign addr = (op == JALR) ? {sum[`RV_XLEN-1:1], 1'b0} : sum;

  // --------------------
  // Misalignment
  always_comb begin
    misaligned = 1'b0;
    case (op)
      JAL, JALR, BR: misaligned = addr[1];  // No compressed ISA, targets need 4B
      LOAD, STORE: begin
        case (size_e'(funct3[1:0]))
          HALF:    misaligned = addr[0];
          WORD:    misaligned = addr[1:0] != 2'b00;
          default: misaligned = 1'b0;  // Bytes always fit
        endcase
      end
      default: misaligned = 1'b0;
    endcase
  end

endmodule

// File: rv_branch_cmp.sv
/* RV32I branch condition evaluation */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_branch_cmp
  import rv_types_pkg::*;
(
  input  br_e                 funct3,
  input  logic [`RV_XLEN-1:0] rs1,
  input  logic [`RV_XLEN-1:0] rs2,
  output logic                taken
);

  logic eq, lt, ltu;

  // One comparator of each kind
  assign eq  = rs1 == rs2;
  assign lt  = $signed(rs1) < $signed(rs2);
  assign ltu = rs1 < rs2;

  always_comb begin
    case (funct3)
      BEQ, BNE:   taken = eq  ^ funct3[0];  // funct3[0] inverts
      BLT, BGE:   taken = lt  ^ funct3[0];
      BLTU, BGEU: taken = ltu ^ funct3[0];
      default:    taken = 1'b0;             // 010, 011 not branches
    endcase
  end

endmodule

// File: rv_decode.sv
/* RV32I instruction decoder with forwarding, store alignment,
   output register and fetch handshake */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode
  import rv_types_pkg::*;
(
  input  logic                clk,
  input  logic                rstz,
  input  logic                flush,
  input  pipe_ifid_t          fetch,
  input  logic [`RV_XLEN-1:0] immediate,
  input  logic [`RV_XLEN-1:0] regrd_rs1,
  input  logic [`RV_XLEN-1:0] regrd_rs2,
  input  logic                fetch_vld,
  output logic                fetch_rdy,
  output pipe_idex_t          decode,
  output logic                decode_vld,
  input  logic                decode_rdy,
  input  logic                regwr_en,
  input  logic [4:0]          regwr_sel,
  input  logic [`RV_XLEN-1:0] regwr_data,
  input  logic                stall,
  output reg_use_t            reg_use,
  output logic                accept
);

  logic [`RV_XLEN-1:0] pc, ir;
  opcode_e             op;
  logic [4:0]          rs1, rs2, rd;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                illegal_opcode;

  logic [`RV_XLEN-1:0] rs1_data, rs2_data;
  logic [`RV_XLEN-1:0] op1, op2, base, offset, addr;
  logic [`RV_XLEN-1:0] store_data;
  aluop_e              aluop;
  sysop_e              sysop;
  logic [3:0]          mask;
  logic                instr_valid, is_fencei, illegal, regwr_alu, writes_rd;
  logic                agu_misaligned, misaligned, taken;
  pipe_idex_t          decode_next;

  // --------------------
  // Instruction fields
  assign pc     = fetch.pc;
  assign ir     = fetch.ir;
  assign op     = opcode_e'(ir[6:2]);
  assign rd     = ir[11:7];
  assign funct3 = ir[14:12];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];
  assign funct7 = ir[31:25];

  assign illegal_opcode = ir[1:0] != 2'b11;  // 16-bit encodings unsupported

  // Writeback bypass, x0 stays zero
  assign rs1_data = (regwr_en && regwr_sel == rs1 && regwr_sel != 5'd0) ? regwr_data : regrd_rs1;
  assign rs2_data = (regwr_en && regwr_sel == rs2 && regwr_sel != 5'd0) ? regwr_data : regrd_rs2;

  // --------------------
  // Operand and validity decode
  always_comb begin
    instr_valid = 1'b0;
    is_fencei   = 1'b0;
    sysop       = NONE;
    aluop       = ADD;
    op1         = pc;        // Link address default
    op2         = `RV_FOUR;
    base        = pc;
    offset      = `RV_FOUR;  // pc+4 for FENCE.I refetch
    case (op)
      LUI: begin
        op1         = `RV_ZERO;
        op2         = immediate;
        instr_valid = 1'b1;
      end
      AUIPC: begin
        op2         = immediate;
        instr_valid = 1'b1;
      end
      JAL: begin
        offset      = immediate;
        instr_valid = 1'b1;
      end
      JALR: begin
        base        = rs1_data;
        offset      = immediate;
        instr_valid = funct3 == 3'b000;
      end
      BR: begin
        offset      = immediate;
        instr_valid = funct3 != 3'b010 && funct3 != 3'b011;
      end
      LOAD: begin
        base        = rs1_data;
        offset      = immediate;
        instr_valid = funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111;
      end
      STORE: begin
        op2         = store_data;
        base        = rs1_data;
        offset      = immediate;
        instr_valid = funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010;
      end
      OPIMM: begin
        op1 = rs1_data;
        op2 = immediate;
        // Only shifts carry funct7
        if (funct3 == 3'b001 || funct3 == 3'b101) aluop = aluop_e'({funct7[5], funct3});
        else aluop = aluop_e'({1'b0, funct3});
        if (funct3 == 3'b001) instr_valid = funct7 == 7'd0;
        else if (funct3 == 3'b101) instr_valid = funct7 == 7'd0 || funct7 == 7'd32;
        else instr_valid = 1'b1;
      end
      OP: begin
        op1   = rs1_data;
        op2   = rs2_data;
        aluop = aluop_e'({funct7[5], funct3});
        // SUB and SRA are the only funct7 variants
        if (funct3 == 3'b000 || funct3 == 3'b101) instr_valid = funct7 == 7'd0 || funct7 == 7'd32;
        else instr_valid = funct7 == 7'd0;
      end
      MISC: begin
        if (funct3 == 3'b000) begin
          instr_valid = funct7[6:3] == 4'd0 && rs1 == 5'd0 && rd == 5'd0;  // FENCE as NOP
        end else if (funct3 == 3'b001 && ir[31:15] == 17'd0 && rd == 5'd0) begin
          is_fencei   = 1'b1;  // Jump to pc+4 so later code is refetched
          instr_valid = 1'b1;
        end
      end
      SYS: begin
        if (funct3 == 3'b000) begin
          if (rs1 == 5'd0 && rd == 5'd0) begin
            instr_valid = 1'b1;
            case (ir[31:20])
              12'h000: sysop = ECALL;
              12'h001: sysop = EBREAK;
              12'h302: sysop = MRET;
              12'h105: sysop = WFI;
              default: instr_valid = 1'b0;
            endcase
          end
        end else if (funct3 != 3'b100) begin
          sysop       = CSR;  // CSRRW/S/C and immediate forms
          instr_valid = 1'b1;
        end
      end
      default: instr_valid = 1'b0;  // Unknown major opcode
    endcase
  end

  assign illegal = !instr_valid || illegal_opcode;

  // --------------------
  // Address and branch
  rv_agu agu_inst (
    .base       (base),
    .offset     (offset),
    .op         (op),
    .funct3     (funct3),
    .addr       (addr),
    .misaligned (agu_misaligned)
  );

  rv_branch_cmp branch_cmp_inst (
    .funct3 (br_e'(funct3)),
    .rs1    (rs1_data),
    .rs2    (rs2_data),
    .taken  (taken)
  );

  // Untaken branch target never matters
  assign misaligned = agu_misaligned && !(op == BR && !taken);

  // --------------------
  // Store alignment
  always_comb begin
    case (addr[1:0])  // Rotate left by byte offset
      2'b00:   store_data = rs2_data;
      2'b01:   store_data = {rs2_data[23:0], rs2_data[31:24]};
      2'b10:   store_data = {rs2_data[15:0], rs2_data[31:16]};
      default: store_data = {rs2_data[7:0], rs2_data[31:8]};
    endcase
    mask = 4'hF;
    if (op == STORE) begin
      case (size_e'(funct3[1:0]))
        BYTE:    mask = 4'h1 << addr[1:0];
        HALF:    mask = addr[1] ? 4'hC : 4'h3;
        default: mask = 4'hF;
      endcase
    end
  end

  // Register usage for the scoreboard
  assign writes_rd = op == LUI || op == AUIPC || op == JAL || op == JALR
                     || op == OPIMM || op == OP || op == LOAD || (op == SYS && funct3 != 3'b000);
  assign regwr_alu = rd != 5'd0 && (op == LUI || op == AUIPC || op == JAL || op == JALR
                                    || op == OPIMM || op == OP);

  assign reg_use.rs1    = rs1;
  assign reg_use.rs1_en = op == JALR || op == BR || op == LOAD || op == STORE
                          || op == OPIMM || op == OP;
  assign reg_use.rs2    = rs2;
  assign reg_use.rs2_en = op == BR || op == STORE || op == OP;
  assign reg_use.rd     = rd;
  assign reg_use.rd_en  = writes_rd && !illegal;  // Illegal ops trap, no write

  // --------------------
  // Decode record
  always_comb begin
    decode_next            = '0;
    decode_next.pc         = pc;
    decode_next.ir         = ir;
    decode_next.aluop      = aluop;
    decode_next.regwr_alu  = regwr_alu;
    decode_next.op1        = op1;
    decode_next.op2        = op2;
    decode_next.addr       = addr;
    decode_next.branch     = op == JAL || op == JALR || (op == BR && taken) || is_fencei;
    decode_next.load       = op == LOAD;
    decode_next.store      = op == STORE;
    decode_next.mask       = mask;
    decode_next.illegal    = illegal;
    decode_next.misaligned = misaligned;
    decode_next.system     = illegal || misaligned || op == SYS;
    decode_next.sysop      = sysop;
  end

  assign fetch_rdy = (!decode_vld || decode_rdy) && !stall;
  assign accept    = fetch_vld && fetch_rdy;

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      decode_vld <= 1'b0;
    end else if (flush) begin
      decode_vld <= 1'b0;
    end else if (accept) begin
      decode_vld <= 1'b1;
    end else if (decode_rdy) begin
      decode_vld <= 1'b0;  // Consumed, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (accept) decode <= decode_next;
  end

endmodule

// File: rv_defines.svh
/* Global width and constant operand macros for the RV32I decode stage */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath and address width
`define RV_XLEN 32

// Architectural register count
`define RV_NREGS 32

// Fixed operands
`define RV_FOUR 32'd4  // Link offset and fall-through step
`define RV_ZERO 32'd0  // LUI op1

`endif

// File: rv_hazard.sv
/* Pending register write scoreboard and RAW stall generation */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_hazard
  import rv_types_pkg::*;
(
  input  logic       clk,
  input  logic       rstz,
  input  logic       flush,
  input  reg_use_t   reg_use,
  input  logic       accept,
  input  logic       regwr_en,
  input  logic [4:0] regwr_sel,
  output logic       stall
);

  logic [`RV_NREGS-1:0] pending;
  logic [`RV_NREGS-1:0] set_vec, clr_vec;
  logic                 rs1_busy, rs2_busy;

  // --------------------
  // Set and clear vectors
  always_comb begin
    set_vec = '0;
    clr_vec = '0;
    if (accept && reg_use.rd_en && reg_use.rd != 5'd0) set_vec[reg_use.rd] = 1'b1;
    if (regwr_en) clr_vec[regwr_sel] = 1'b1;
  end

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      pending <= '0;
    end else if (flush) begin
      pending <= '0;  // Everything in flight is dropped
    end else begin
      pending <= (pending | set_vec) & ~clr_vec;  // Clear wins on collision
    end
  end

  // --------------------
  // RAW check with a same-cycle writeback forwarded instead
  assign rs1_busy = reg_use.rs1_en && pending[reg_use.rs1]
                    && !(regwr_en && regwr_sel == reg_use.rs1);
  assign rs2_busy = reg_use.rs2_en && pending[reg_use.rs2]
                    && !(regwr_en && regwr_sel == reg_use.rs2);

  assign stall = rs1_busy || rs2_busy;

endmodule

// File: rv_id_stage.sv
/* Decode stage top with decoder and hazard unit */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_id_stage
  import rv_types_pkg::*;
(
  input  logic                clk,
  input  logic                rstz,
  input  logic                flush,
  input  pipe_ifid_t          fetch,
  input  logic [`RV_XLEN-1:0] immediate,
  input  logic [`RV_XLEN-1:0] regrd_rs1,
  input  logic [`RV_XLEN-1:0] regrd_rs2,
  input  logic                fetch_vld,
  output logic                fetch_rdy,
  output pipe_idex_t          decode,
  output logic                decode_vld,
  input  logic                decode_rdy,
  input  logic                regwr_en,
  input  logic [4:0]          regwr_sel,
  input  logic [`RV_XLEN-1:0] regwr_data
);

  reg_use_t reg_use;
  logic     accept, stall;

  rv_decode decode_inst (
    .clk        (clk),
    .rstz       (rstz),
    .flush      (flush),
    .fetch      (fetch),
    .immediate  (immediate),
    .regrd_rs1  (regrd_rs1),
    .regrd_rs2  (regrd_rs2),
    .fetch_vld  (fetch_vld),
    .fetch_rdy  (fetch_rdy),
    .decode     (decode),
    .decode_vld (decode_vld),
    .decode_rdy (decode_rdy),
    .regwr_en   (regwr_en),
    .regwr_sel  (regwr_sel),
    .regwr_data (regwr_data),
    .stall      (stall),
    .reg_use    (reg_use),
    .accept     (accept)
  );

  rv_hazard hazard_inst (
    .clk       (clk),
    .rstz      (rstz),
    .flush     (flush),
    .reg_use   (reg_use),
    .accept    (accept),
    .regwr_en  (regwr_en),
    .regwr_sel (regwr_sel),
    .stall     (stall)
  );

endmodule

// File: rv_types_pkg.sv
/* Opcode, ALU, branch, size and system-op enums
   plus the pipeline and register-use structs of the decode stage */
`include "rv_defines.svh"

package rv_types_pkg;

  // Major opcodes, ir[6:2]
  typedef enum logic [4:0] {
    LOAD  = 5'b00000,
    MISC  = 5'b00011,
    OPIMM = 5'b00100,
    AUIPC = 5'b00101,
    STORE = 5'b01000,
    OP    = 5'b01100,
    LUI   = 5'b01101,
    BR    = 5'b11000,
    JALR  = 5'b11001,
    JAL   = 5'b11011,
    SYS   = 5'b11100
  } opcode_e;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SLL  = 4'b0001,
    SLT  = 4'b0010,
    SLTU = 4'b0011,
    XOR  = 4'b0100,
    SRL  = 4'b0101,
    OR   = 4'b0110,
    AND  = 4'b0111,
    SUB  = 4'b1000,
    SRA  = 4'b1101
  } aluop_e;

  typedef enum logic [2:0] {
    BEQ = 3'b000, BNE = 3'b001, BLT = 3'b100, BGE = 3'b101, BLTU = 3'b110, BGEU = 3'b111
  } br_e;

  typedef enum logic [1:0] {BYTE = 2'b00, HALF = 2'b01, WORD = 2'b10} size_e;

  typedef enum logic [2:0] {
    NONE = 3'd0, ECALL = 3'd1, EBREAK = 3'd2, MRET = 3'd3, WFI = 3'd4, CSR = 3'd5
  } sysop_e;

  // -------------------
  // Pipeline records
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] ir;
  } pipe_ifid_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] ir;
    aluop_e              aluop;
    logic                regwr_alu;  // ALU result goes to rd
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [`RV_XLEN-1:0] addr;       // Jump/branch target or memory address
    logic                branch;
    logic                load;
    logic                store;
    logic [3:0]          mask;       // Store byte enables
    logic                illegal;
    logic                misaligned;
    logic                system;     // Needs the system unit
    sysop_e              sysop;
  } pipe_idex_t;

  // Register use of the instruction in decode
  typedef struct packed {
    logic [4:0] rs1;
    logic       rs1_en;
    logic [4:0] rs2;
    logic       rs2_en;
    logic [4:0] rd;
    logic       rd_en;
  } reg_use_t;

endpackage

// File: tb_rv_id_tests.svh
/* Directed decode stage tests with the fetch and writeback driver tasks */
`ifndef TB_RV_ID_TESTS_SVH
`define TB_RV_ID_TESTS_SVH

// Present one instruction and wait until it is taken
task automatic issue(input logic [31:0] pc, ir, imm, r1, r2, input logic retire);
  @(negedge clk);
  fetch.pc  = pc;
  fetch.ir  = ir;
  immediate = imm;
  regrd_rs1 = r1;
  regrd_rs2 = r2;
  fetch_vld = 1'b1;
  regwr_en  = 1'b0;
  #1;
  while (!fetch_rdy) begin
    @(negedge clk);
    #1;
  end
  @(negedge clk);
  fetch_vld = 1'b0;
  regwr_en  = retire;    // Writeback of rd one cycle later
  regwr_sel = ir[11:7];
endtask

task automatic check_alu(input string name, input logic [31:0] e1, e2,
                         input aluop_e eop, input logic ewr);
  check(name, e1, decode.op1);
  check(name, e2, decode.op2);
  check(name, 32'(eop), 32'(decode.aluop));
  check(name, 32'(ewr), 32'(decode.regwr_alu));
endtask

task automatic check_sys(input string name, input logic ill, sys, input sysop_e sop);
  check(name, 32'(ill), 32'(decode.illegal));
  check(name, 32'(sys), 32'(decode.system));
  check(name, 32'(sop), 32'(decode.sysop));
endtask

// --------------------
task automatic decode_alu_ops();
  int          e0;
  logic [31:0] pc, imm, a, b;
  e0  = errors;
  pc  = rand_bits(30) << 2;
  imm = rand_bits(32);
  a   = rand_bits(32);
  b   = rand_bits(32);
  issue(pc, {imm[31:12], 5'd3, LUI, 2'b11}, {imm[31:12], 12'd0}, a, b, 1'b1);
  check_alu("alu lui", 32'd0, {imm[31:12], 12'd0}, ADD, 1'b1);
  issue(pc, {imm[31:12], 5'd3, AUIPC, 2'b11}, {imm[31:12], 12'd0}, a, b, 1'b1);
  check_alu("alu auipc", pc, {imm[31:12], 12'd0}, ADD, 1'b1);
  check("alu auipc pc", pc, decode.pc);
  issue(pc, {imm[31:12], 5'd1, JAL, 2'b11}, imm & 32'hFFFF_FFFC, a, b, 1'b1);
  check_alu("alu jal", pc, 32'd4, ADD, 1'b1);  // Link value pc+4
  issue(pc, enc_i(imm[11:0], 5'd2, 3'b000, 5'd4, OPIMM), {{20{imm[11]}}, imm[11:0]}, a, b, 1'b1);
  check_alu("alu addi", a, {{20{imm[11]}}, imm[11:0]}, ADD, 1'b1);
  issue(pc, enc_r(7'b0100000, 5'd7, 5'd2, 3'b101, 5'd4, OPIMM), 32'h407, a, b, 1'b1);
  check_alu("alu srai", a, 32'h407, SRA, 1'b1);
  issue(pc, enc_r(7'd0, 5'd3, 5'd2, 3'b000, 5'd4, OP), imm, a, b, 1'b1);
  check_alu("alu add", a, b, ADD, 1'b1);
  issue(pc, enc_r(7'b0100000, 5'd3, 5'd2, 3'b000, 5'd4, OP), imm, a, b, 1'b1);
  check_alu("alu sub", a, b, SUB, 1'b1);
  issue(pc, enc_r(7'b0100000, 5'd3, 5'd2, 3'b101, 5'd4, OP), imm, a, b, 1'b1);
  check_alu("alu sra", a, b, SRA, 1'b1);
  issue(pc, enc_r(7'd0, 5'd3, 5'd2, 3'b100, 5'd0, OP), imm, a, b, 1'b1);
  check_alu("alu xor x0", a, b, XOR, 1'b0);  // No write to x0
  report("alu", e0);
endtask

task automatic resolve_branches();
  int          e0;
  logic [31:0] pc, imm, a, b;
  logic [2:0]  f3;
  e0 = errors;
  for (int i = 0; i < 8; i++) begin
    if (i == 2 || i == 3) continue;  // Not branch codes
    f3 = i[2:0];
    for (int p = 0; p < 4; p++) begin
      pc  = rand_bits(30) << 2;
      imm = rand_bits(32) & 32'hFFFF_FFFC;
      a   = rand_bits(32);
      b   = (p == 1) ? a : rand_bits(32);
      if (p == 2) begin
        a = 32'h8000_0000;  // Most negative vs most positive
        b = 32'h7FFF_FFFF;
      end else if (p == 3) begin
        a = 32'hFFFF_FFFF;  // Signed and unsigned order disagree
        b = 32'd1;
      end
      issue(pc, enc_r(7'd0, 5'd3, 5'd2, f3, 5'd0, BR), imm, a, b, 1'b0);
      check("branch taken", 32'(exp_taken(f3, a, b)), 32'(decode.branch));
      check("branch addr", pc + imm, decode.addr);
    end
  end
  report("branch", e0);
endtask

task automatic address_memory();
  int          e0;
  logic [31:0] base, imm, d, addr;
  logic [1:0]  off;
  logic        mis;
  e0 = errors;
  for (int s = 0; s < 3; s++) begin
    for (int o = 0; o < 4; o++) begin
      off  = o[1:0];
      base = rand_bits(32) & 32'hFFFF_FFFC;
      imm  = (rand_bits(10) << 2) | {30'd0, off};
      d    = rand_bits(32);
      addr = base + imm;
      mis  = (s == 1) ? off[0] : ((s == 2) ? (off != 2'd0) : 1'b0);
      issue(rand_bits(30) << 2, enc_i(12'd0, 5'd2, {1'b0, s[1:0]}, 5'd4, LOAD), imm, base, d,
            1'b1);
      check("load addr", addr, decode.addr);
      check("load misaligned", 32'(mis), 32'(decode.misaligned));
      check("load flags", 32'd2, {30'd0, decode.load, decode.store});
      issue(rand_bits(30) << 2, enc_r(7'd0, 5'd3, 5'd2, {1'b0, s[1:0]}, 5'd0, STORE), imm, base,
            d, 1'b0);
      check("store addr", addr, decode.addr);
      check("store mask", 32'(exp_mask(s[1:0], off)), 32'(decode.mask));
      check("store data", exp_rot(d, off), decode.op2);
      check("store misaligned", 32'(mis), 32'(decode.misaligned));
      check("store flags", 32'd1, {30'd0, decode.load, decode.store});
    end
  end
  // JALR target base+3 loses bit 0 and keeps bit 1 set
  base = rand_bits(32) & 32'hFFFF_FFFC;
  issue(rand_bits(30) << 2, enc_i(12'd3, 5'd2, 3'b000, 5'd1, JALR), 32'd3, base, 32'd0, 1'b1);
  check("jalr addr", base + 32'd2, decode.addr);
  check("jalr misaligned", 32'd1, 32'(decode.misaligned));
  report("memory", e0);
endtask

task automatic flag_system_ops();
  int          e0;
  logic [31:0] pc;
  e0 = errors;
  pc = rand_bits(30) << 2;
  issue(pc, enc_i(12'd1, 5'd2, 3'b000, 5'd4, OPIMM) & ~32'd1, 32'd1, 32'd0, 32'd0, 1'b1);
  check_sys("sys low bits", 1'b1, 1'b1, NONE);
  issue(pc, enc_r(7'b0000001, 5'd3, 5'd2, 3'b000, 5'd4, OP), 32'd0, 32'd0, 32'd0, 1'b1);
  check_sys("sys funct7", 1'b1, 1'b1, NONE);
  issue(pc, enc_i(12'h0FF, 5'd0, 3'b000, 5'd0, MISC), 32'd0, 32'd0, 32'd0, 1'b0);
  check_sys("sys fence", 1'b0, 1'b0, NONE);
  check("sys fence branch", 32'd0, 32'(decode.branch));
  issue(pc, enc_i(12'd0, 5'd0, 3'b001, 5'd0, MISC), 32'd0, 32'd0, 32'd0, 1'b0);
  check_sys("sys fence.i", 1'b0, 1'b0, NONE);
  check("sys fence.i branch", 32'd1, 32'(decode.branch));
  check("sys fence.i addr", pc + 32'd4, decode.addr);  // Refetch the next instruction
  issue(pc, enc_i(12'h000, 5'd0, 3'b000, 5'd0, SYS), 32'd0, 32'd0, 32'd0, 1'b0);
  check_sys("sys ecall", 1'b0, 1'b1, ECALL);
  issue(pc, enc_i(12'h001, 5'd0, 3'b000, 5'd0, SYS), 32'd0, 32'd0, 32'd0, 1'b0);
  check_sys("sys ebreak", 1'b0, 1'b1, EBREAK);
  issue(pc, enc_i(12'h302, 5'd0, 3'b000, 5'd0, SYS), 32'd0, 32'd0, 32'd0, 1'b0);
  check_sys("sys mret", 1'b0, 1'b1, MRET);
  issue(pc, enc_i(12'h105, 5'd0, 3'b000, 5'd0, SYS), 32'd0, 32'd0, 32'd0, 1'b0);
  check_sys("sys wfi", 1'b0, 1'b1, WFI);
  issue(pc, enc_i(12'h300, 5'd2, 3'b001, 5'd1, SYS), 32'd0, 32'd0, 32'd0, 1'b1);
  check_sys("sys csrrw", 1'b0, 1'b1, CSR);
  report("system", e0);
endtask

// --------------------
task automatic stall_on_hazard();
  int          e0;
  logic [31:0] a, wb;
  e0 = errors;
  a  = rand_bits(32);
  wb = rand_bits(32);
  issue(rand_bits(30) << 2, enc_i(12'd1, 5'd1, 3'b000, 5'd5, OPIMM), 32'd1, a, 32'd0, 1'b0);
  // ADD x6, x5, x7 behind the pending x5
  @(negedge clk);
  fetch.ir  = enc_r(7'd0, 5'd7, 5'd5, 3'b000, 5'd6, OP);
  regrd_rs1 = ~wb;  // Stale register file value
  regrd_rs2 = a;
  fetch_vld = 1'b1;
  repeat (4) begin
    #1;
    check("hazard stall", 32'd0, 32'(fetch_rdy));
    @(negedge clk);
  end
  regwr_en   = 1'b1;
  regwr_sel  = 5'd5;
  regwr_data = wb;
  #1;
  check("hazard release", 32'd1, 32'(fetch_rdy));
  @(negedge clk);
  fetch_vld = 1'b0;
  regwr_sel = 5'd6;  // Retire x6 too
  check("hazard forward", wb, decode.op1);
  check("hazard op2", a, decode.op2);
  report("hazard", e0);
endtask

task automatic hold_and_flush();
  int          e0;
  logic [31:0] a, ir;
  e0 = errors;
  a  = rand_bits(32);
  ir = enc_i(12'd8, 5'd1, 3'b000, 5'd9, OPIMM);  // ADDI x9, x1, 8
  @(negedge clk);
  regwr_en   = 1'b0;
  decode_rdy = 1'b0;
  issue(rand_bits(30) << 2, ir, 32'd8, a, 32'd0, 1'b0);
  fetch.ir  = enc_i(12'd1, 5'd0, 3'b000, 5'd10, OPIMM);  // Waits behind the full output
  fetch_vld = 1'b1;
  repeat (3) begin
    #1;
    check("hold valid", 32'd1, 32'(decode_vld));
    check("hold fetch_rdy", 32'd0, 32'(fetch_rdy));
    check("hold ir", ir, decode.ir);
    check("hold op1", a, decode.op1);
    @(negedge clk);
  end
  fetch_vld = 1'b0;
  flush     = 1'b1;
  @(negedge clk);
  flush = 1'b0;
  check("flush valid", 32'd0, 32'(decode_vld));
  // ADD x11, x9, x0 goes through once x9 has left the scoreboard
  fetch.ir   = enc_r(7'd0, 5'd0, 5'd9, 3'b000, 5'd11, OP);
  fetch_vld  = 1'b1;
  decode_rdy = 1'b1;
  #1;
  check("flush scoreboard", 32'd1, 32'(fetch_rdy));
  @(negedge clk);
  fetch_vld = 1'b0;
  report("handshake", e0);
endtask

`endif

// File: tb_rv_id_stage.sv
/* Testbench top for the RV32I decode stage with clock, reset, DUT, LFSR,
   instruction encoders, expected-value model, timeout and summary */
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_id_stage
  import rv_types_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 1000;  // About five times the ~200 cycles of all tests

  logic                clk;
  logic                rstz;
  logic                flush;
  pipe_ifid_t          fetch;
  logic [`RV_XLEN-1:0] immediate, regrd_rs1, regrd_rs2;
  logic                fetch_vld, fetch_rdy;
  pipe_idex_t          decode;
  logic                decode_vld, decode_rdy;
  logic                regwr_en;
  logic [4:0]          regwr_sel;
  logic [`RV_XLEN-1:0] regwr_data;

  int          errors = 0;
  int          checks = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  logic [15:0] lfsr_state = 16'd40968;

  rv_id_stage rv_id_stage_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------
  // Galois LFSR x^16+x^14+x^13+x^11+1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r          = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
    end
    return r;
  endfunction

  // --------------------
  // Encoders and expected values
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcode_e op);
    return {f7, rs2, rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcode_e op);
    return enc_r(imm[11:5], imm[4:0], rs1, f3, rd, op);  // I-type shares the R layout
  endfunction

  function automatic logic exp_taken(input logic [2:0] f3, input logic [31:0] a, b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Lanes inside the naturally aligned container of the access
  function automatic logic [3:0] exp_mask(input logic [1:0] size, input logic [1:0] off);
    logic [3:0] m;
    int         n;
    n = 1 << size;  // Bytes per access
    for (int j = 0; j < 4; j++) m[j] = (j / n) == (int'(off) / n);
    return m;
  endfunction

  // Byte k of the store data lands in lane k+off
  function automatic logic [31:0] exp_rot(input logic [31:0] d, input logic [1:0] off);
    logic [31:0] r;
    int          o;
    r = '0;
    o = int'(off);
    for (int k = 0; k < 4; k++) r[8*((k + o) % 4) +: 8] = d[8*k +: 8];
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, act);
    checks++;
    assert (act === exp) else begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  `include "tb_rv_id_tests.svh"

  // --------------------
  // Main sequence
  initial begin
    rstz       = 1'b0;
    flush      = 1'b0;
    fetch      = '0;
    immediate  = '0;
    regrd_rs1  = '0;
    regrd_rs2  = '0;
    fetch_vld  = 1'b0;
    decode_rdy = 1'b1;
    regwr_en   = 1'b0;
    regwr_sel  = 5'd0;
    regwr_data = '0;
    repeat (10) @(negedge clk);
    rstz = 1'b1;
    decode_alu_ops();
    resolve_branches();
    address_memory();
    flag_system_ops();
    stall_on_hazard();
    hold_and_flush();
    $display("tests failed %0d of 6, checks %0d, errors %0d", tests_failed, checks, errors);
    if (errors == 0) $display("TESTBENCH PASSED");
    else $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
